//--- Makefile
TOP := raster_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f filelist.f --top-module $(TOP) -o $(TOP)_sim
	./obj_dir/$(TOP)_sim

clean:
	rm -rf obj_dir

//--- design/bbox_finder.sv
`timescale 1ns/1ps
`default_nettype none
`include "raster_cfg.svh"

module bbox_finder
  import raster_pkg::*;
(
  input  wire       clk_in,
  input  wire       rst_in,
  input  wire       start,
  input  wire tri_t tri_in,
  output bbox_t     box
);

  localparam int HW   = `RASTER_HW;
  localparam int VW   = `RASTER_VW;
  localparam int HMAX = `RASTER_HRES - 1;
  localparam int VMAX = `RASTER_VRES - 1;

  int    x_lo, x_hi, y_lo, y_hi;
  bbox_t box_c;

  function automatic int min3(input int a, input int b, input int c);
    int m;
    m = (a < b) ? a : b;
    min3 = (m < c) ? m : c;
  endfunction

  function automatic int max3(input int a, input int b, input int c);
    int m;
    m = (a > b) ? a : b;
    max3 = (m > c) ? m : c;
  endfunction

  always_comb begin
    x_lo = min3(tri_in.v0.x, tri_in.v1.x, tri_in.v2.x);
    x_hi = max3(tri_in.v0.x, tri_in.v1.x, tri_in.v2.x);
    y_lo = min3(tri_in.v0.y, tri_in.v1.y, tri_in.v2.y);
    y_hi = max3(tri_in.v0.y, tri_in.v1.y, tri_in.v2.y);
    box_c.h_min = (x_lo < 0) ? '0 : HW'(x_lo);       // clip to left edge
    box_c.h_max = (x_hi > HMAX) ? HW'(HMAX) : HW'(x_hi);
    box_c.v_min = (y_lo < 0) ? '0 : VW'(y_lo);
    box_c.v_max = (y_hi > VMAX) ? VW'(VMAX) : VW'(y_hi);
    // whole triangle lies off one side of the frame
    box_c.empty = (x_hi < 0) || (x_lo > HMAX) || (y_hi < 0) || (y_lo > VMAX);
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      box <= '{h_min: '0, h_max: '0, v_min: '0, v_max: '0, empty: 1'b1};
    end else if (start) begin
      box <= box_c;
    end
  end

  a_box_ordered: assert property (@(posedge clk_in) disable iff (rst_in)
    start |=> box.empty || (box.h_min <= box.h_max && box.v_min <= box.v_max));

endmodule

`default_nettype wire

//--- design/edge_interpolator.sv
`timescale 1ns/1ps
`default_nettype none
`include "raster_cfg.svh"

module edge_interpolator
  import raster_pkg::*;
(
  input  wire                       clk_in,
  input  wire                       rst_in,
  input  wire tri_t                 tri_in,
  input  wire                       neg,
  input  wire [`RASTER_INV_FRAC:0]  inv,
  input  wire                       cand_valid,
  input  wire pixel_t               cand,
  input  wire                       stall,
  output logic                      pix_valid,
  output pixel_t                    pix_out,
  output logic                      busy
);

  localparam int HW = `RASTER_HW;
  localparam int VW = `RASTER_VW;
  localparam int ZW = `RASTER_ZW;
  localparam int AW = `RASTER_AW;
  localparam int IF = `RASTER_INV_FRAC;
  localparam int EW = AW + 2;        // headroom for pixels outside the triangle
  localparam int SW = AW + ZW + 2;   // weighted depth sum
  localparam int PW = SW + IF + 1;

  logic signed [EW-1:0] xs [3];
  logic signed [EW-1:0] ys [3];
  logic signed [EW-1:0] px, py;
  logic signed [EW-1:0] w_c [3];
  logic                 covered_c;
  logic [SW-1:0]        sum_c;
  logic [PW-1:0]        prod_c;

  logic                 s1_valid;
  logic [HW-1:0]        s1_h;
  logic [VW-1:0]        s1_v;
  logic signed [EW-1:0] s1_w [3];
  logic                 s2_valid;
  logic [HW-1:0]        s2_h;
  logic [VW-1:0]        s2_v;
  logic [SW-1:0]        s2_sum;

  // edge a->b evaluated at c, positive on the left for ccw winding
  function automatic logic signed [EW-1:0] edge_fn(
    input logic signed [EW-1:0] ax, input logic signed [EW-1:0] ay,
    input logic signed [EW-1:0] bx, input logic signed [EW-1:0] by,
    input logic signed [EW-1:0] cx, input logic signed [EW-1:0] cy);
    edge_fn = (bx - ax) * (cy - ay) - (by - ay) * (cx - ax);
  endfunction

  always_comb begin
    xs[0] = EW'($signed(tri_in.v0.x));
    xs[1] = EW'($signed(tri_in.v1.x));
    xs[2] = EW'($signed(tri_in.v2.x));
    ys[0] = EW'($signed(tri_in.v0.y));
    ys[1] = EW'($signed(tri_in.v1.y));
    ys[2] = EW'($signed(tri_in.v2.y));
    px = EW'(cand.h);
    py = EW'(cand.v);
    w_c[0] = edge_fn(xs[1], ys[1], xs[2], ys[2], px, py);  // weight of v0
    w_c[1] = edge_fn(xs[2], ys[2], xs[0], ys[0], px, py);
    w_c[2] = edge_fn(xs[0], ys[0], xs[1], ys[1], px, py);
    for (int i = 0; i < 3; i++) begin
      if (neg) w_c[i] = -w_c[i];                          // cw triangle
    end
  end

  // weights of covered pixels are bounded by |area| and fit in AW bits
  assign covered_c = !s1_w[0][EW-1] && !s1_w[1][EW-1] && !s1_w[2][EW-1];
  assign sum_c = SW'(s1_w[0][AW-1:0]) * SW'(tri_in.v0.z)
               + SW'(s1_w[1][AW-1:0]) * SW'(tri_in.v1.z)
               + SW'(s1_w[2][AW-1:0]) * SW'(tri_in.v2.z);
  assign prod_c = PW'(s2_sum) * PW'(inv);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      s1_valid  <= 1'b0;
      s2_valid  <= 1'b0;
      pix_valid <= 1'b0;
    end else if (!stall) begin
      s1_valid  <= cand_valid;
      s2_valid  <= s1_valid && covered_c;  // uncovered drops out as a bubble
      pix_valid <= s2_valid;
    end
  end

  always_ff @(posedge clk_in) begin
    if (!stall) begin
      s1_h    <= cand.h;
      s1_v    <= cand.v;
      s1_w    <= w_c;
      s2_h    <= s1_h;
      s2_v    <= s1_v;
      s2_sum  <= sum_c;
      pix_out <= '{h: s2_h, v: s2_v, z: prod_c[IF +: ZW]};
    end
  end

  assign busy = s1_valid || s2_valid || pix_valid;

endmodule

`default_nettype wire

//--- design/inv_area.sv
`timescale 1ns/1ps
`default_nettype none
`include "raster_cfg.svh"

module inv_area
  import raster_pkg::*;
(
  input  wire                       clk_in,
  input  wire                       rst_in,
  input  wire                       start,
  input  wire tri_t                 tri_in,
  output logic                      done,
  output logic                      zero,
  output logic                      neg,
  output logic [`RASTER_INV_FRAC:0] inv
);

  localparam int AW = `RASTER_AW;
  localparam int IF = `RASTER_INV_FRAC;
  localparam int CW = $clog2(IF);

  logic signed [AW-1:0] dx1, dy1, dx2, dy2;
  logic signed [AW-1:0] area_c;
  logic [AW-1:0]        mag_c;
  logic [AW-1:0]        div_q;   // |area|
  logic [AW-1:0]        rem_q;
  logic [AW:0]          rem_sh;
  logic                 fits;
  logic [CW-1:0]        cnt_q;
  logic                 busy_q;

  always_comb begin
    dx1 = AW'($signed(tri_in.v1.x)) - AW'($signed(tri_in.v0.x));
    dy1 = AW'($signed(tri_in.v1.y)) - AW'($signed(tri_in.v0.y));
    dx2 = AW'($signed(tri_in.v2.x)) - AW'($signed(tri_in.v0.x));
    dy2 = AW'($signed(tri_in.v2.y)) - AW'($signed(tri_in.v0.y));
    area_c = dx1 * dy2 - dx2 * dy1;                  // doubled signed area
    mag_c  = area_c[AW-1] ? AW'(-area_c) : AW'(area_c);
    rem_sh = {rem_q, 1'b0};                          // dividend bits below the top one are 0
    fits   = (rem_sh >= {1'b0, div_q});
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy_q <= 1'b0;
      done   <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy_q <= 1'b1;
      end else if (busy_q && cnt_q == CW'(IF - 1)) begin
        busy_q <= 1'b0;
        done   <= 1'b1;
      end
    end
  end

  // the top quotient bit of 2^IF / d is resolved while loading,
  // it is only set for d == 1
  always_ff @(posedge clk_in) begin
    if (start) begin
      neg   <= area_c[AW-1];
      zero  <= (area_c == '0);
      div_q <= mag_c;
      rem_q <= (mag_c == AW'(1)) ? '0 : AW'(1);
      inv   <= {{IF{1'b0}}, (mag_c == AW'(1))};
      cnt_q <= '0;
    end else if (busy_q) begin
      rem_q <= fits ? AW'(rem_sh - {1'b0, div_q}) : AW'(rem_sh);  // restore on miss
      inv   <= {inv[IF-1:0], fits};
      cnt_q <= cnt_q + 1'b1;
    end
  end

  a_done_pulse: assert property (@(posedge clk_in) disable iff (rst_in)
    done |=> !done);

endmodule

`default_nettype wire

//--- design/pixel_scanner.sv
`timescale 1ns/1ps
`default_nettype none
`include "raster_cfg.svh"

module pixel_scanner
  import raster_pkg::*;
(
  input  wire        clk_in,
  input  wire        rst_in,
  input  wire        start,
  input  wire bbox_t box,
  input  wire        stall,
  output logic       cand_valid,
  output pixel_t     cand,
  output logic       last
);

  localparam int HW = `RASTER_HW;
  localparam int VW = `RASTER_VW;

  logic [HW-1:0] h_q;
  logic [VW-1:0] v_q;
  logic          active_q;
  logic          row_end;
  logic          advance;

  assign row_end    = (h_q == box.h_max);
  assign last       = active_q && row_end && (v_q == box.v_max);
  assign advance    = active_q && !stall;  // candidate taken by the pipeline
  assign cand_valid = active_q;
  assign cand       = '{h: h_q, v: v_q, z: '0};

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      active_q <= 1'b0;
    end else if (start) begin
      active_q <= !box.empty;
    end else if (advance && last) begin
      active_q <= 1'b0;
    end
  end

  // raster order, h fastest
  always_ff @(posedge clk_in) begin
    if (start) begin
      h_q <= box.h_min;
      v_q <= box.v_min;
    end else if (advance && !last) begin
      if (row_end) begin
        h_q <= box.h_min;
        v_q <= v_q + 1'b1;
      end else begin
        h_q <= h_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/raster_pkg.sv
`default_nettype none
`include "raster_cfg.svh"

package raster_pkg;

  // x and y are signed so a corner may sit left of or above the frame
  typedef struct packed {
    logic signed [`RASTER_HW-1:0] x;
    logic signed [`RASTER_VW-1:0] y;
    logic [`RASTER_ZW-1:0]        z;
  } vertex_t;

  typedef struct packed {
    vertex_t v0;
    vertex_t v1;
    vertex_t v2;
  } tri_t;

  typedef struct packed {
    logic [`RASTER_HW-1:0] h_min;
    logic [`RASTER_HW-1:0] h_max;
    logic [`RASTER_VW-1:0] v_min;
    logic [`RASTER_VW-1:0] v_max;
    logic                  empty;  // clipped box holds no pixel
  } bbox_t;

  typedef struct packed {
    logic [`RASTER_HW-1:0] h;
    logic [`RASTER_VW-1:0] v;
    logic [`RASTER_ZW-1:0] z;
  } pixel_t;

  typedef enum logic [2:0] {
    IDLE,
    BBOX,
    AREA,
    SCAN,
    DRAIN
  } raster_state_e;

endpackage

`default_nettype wire

//--- design/raster_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "raster_cfg.svh"

module raster_top
  import raster_pkg::*;
(
  input  wire       clk_in,
  input  wire       rst_in,
  input  wire tri_t tri_in,
  input  wire       tri_valid,
  output logic      tri_ready,
  output pixel_t    pix_out,
  output logic      pix_valid,
  input  wire       pix_ready
);

  tri_t                      tri_q;
  bbox_t                     box;
  pixel_t                    cand;
  logic                      stall;
  logic                      bbox_start;
  logic                      area_start;
  logic                      scan_start;
  logic                      area_done;
  logic                      area_zero;
  logic                      area_neg;
  logic [`RASTER_INV_FRAC:0] inv;
  logic                      cand_valid;
  logic                      scan_last;
  logic                      pipe_busy;

  rasterizer rasterizer_i (
    .clk_in(clk_in), .rst_in(rst_in),
    .tri_in(tri_in), .tri_valid(tri_valid), .tri_ready(tri_ready),
    .pix_ready(pix_ready), .pix_valid(pix_valid),
    .tri_q(tri_q), .stall(stall),
    .bbox_start(bbox_start), .box(box),
    .area_start(area_start), .area_done(area_done), .area_zero(area_zero),
    .scan_start(scan_start), .scan_last(scan_last), .pipe_busy(pipe_busy)
  );

  bbox_finder bbox_finder_i (
    .clk_in(clk_in), .rst_in(rst_in),
    .start(bbox_start), .tri_in(tri_q), .box(box)
  );

  inv_area inv_area_i (
    .clk_in(clk_in), .rst_in(rst_in),
    .start(area_start), .tri_in(tri_q),
    .done(area_done), .zero(area_zero), .neg(area_neg), .inv(inv)
  );

  pixel_scanner pixel_scanner_i (
    .clk_in(clk_in), .rst_in(rst_in),
    .start(scan_start), .box(box), .stall(stall),
    .cand_valid(cand_valid), .cand(cand), .last(scan_last)
  );

  edge_interpolator edge_interpolator_i (
    .clk_in(clk_in), .rst_in(rst_in),
    .tri_in(tri_q), .neg(area_neg), .inv(inv),
    .cand_valid(cand_valid), .cand(cand), .stall(stall),
    .pix_valid(pix_valid), .pix_out(pix_out), .busy(pipe_busy)
  );

endmodule

`default_nettype wire

//--- design/rasterizer.sv
`timescale 1ns/1ps
`default_nettype none

module rasterizer
  import raster_pkg::*;
(
  input  wire        clk_in,
  input  wire        rst_in,
  input  wire tri_t  tri_in,
  input  wire        tri_valid,
  output logic       tri_ready,
  input  wire        pix_ready,
  input  wire        pix_valid,
  output tri_t       tri_q,
  output logic       stall,
  output logic       bbox_start,
  input  wire bbox_t box,
  output logic       area_start,
  input  wire        area_done,
  input  wire        area_zero,
  output logic       scan_start,
  input  wire        scan_last,
  input  wire        pipe_busy
);

  raster_state_e state;
  logic          accept;

  assign tri_ready  = (state == IDLE);
  assign accept     = tri_valid && tri_ready;
  assign bbox_start = (state == BBOX);          // box registers at the end of this cycle
  assign stall      = pix_valid && !pix_ready;  // output held, freeze scan and pipe

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state      <= IDLE;
      area_start <= 1'b0;
      scan_start <= 1'b0;
    end else begin
      area_start <= 1'b0;
      scan_start <= 1'b0;
      case (state)
        IDLE: begin
          if (accept) state <= BBOX;
        end
        BBOX: begin
          state      <= AREA;
          area_start <= 1'b1;
        end
        AREA: begin
          if (area_done) begin
            if (area_zero || box.empty) begin
              state <= IDLE;  // nothing to draw
            end else begin
              state      <= SCAN;
              scan_start <= 1'b1;
            end
          end
        end
        SCAN: begin
          if (scan_last && !stall) state <= DRAIN;
        end
        DRAIN: begin
          if (!pipe_busy) state <= IDLE;  // last pixel has left the output
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (accept) begin
      tri_q <= tri_in;
    end
  end

  // a new triangle is only taken once the pipeline holds nothing of the last one
  a_accept_idle: assert property (@(posedge clk_in) disable iff (rst_in)
    accept |-> !pipe_busy);

  // the divider only reports for a triangle this FSM is waiting on
  a_done_in_area: assert property (@(posedge clk_in) disable iff (rst_in)
    area_done |-> state == AREA);

endmodule

`default_nettype wire

//--- filelist.f
+incdir+include
design/raster_pkg.sv
design/bbox_finder.sv
design/inv_area.sv
design/pixel_scanner.sv
design/edge_interpolator.sv
design/rasterizer.sv
design/raster_top.sv
tests/raster_tb.sv

//--- include/raster_cfg.svh
`ifndef RASTER_CFG_SVH
`define RASTER_CFG_SVH

// frame size in pixels
`define RASTER_HRES 64
`define RASTER_VRES 64

// vertex and pixel coordinate widths
`define RASTER_HW 6
`define RASTER_VW 6

`define RASTER_ZW 16        // unsigned depth
`define RASTER_INV_FRAC 16  // fraction bits of 1/|area|
`define RASTER_AW 14        // signed doubled area

`endif

//--- tests/raster_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "raster_cfg.svh"

module raster_tb
  import raster_pkg::*;
;

  localparam int CLK_PERIOD      = 100;
  localparam int N_TRI           = 6;     // triangles sent over all tests
  localparam int MAX_BOX         = 32 * 32;
  localparam int TRI_CYCLES      = 40 + 4 * MAX_BOX;  // setup plus a stalled scan
  localparam int WATCHDOG_CYCLES = 8 + N_TRI * TRI_CYCLES;

  logic        clk_in;
  logic        rst_in;
  tri_t        tri_in;
  logic        tri_valid;
  logic        tri_ready;
  pixel_t      pix_out;
  logic        pix_valid;
  logic        pix_ready = 1'b1;

  logic        bp_on;
  logic [31:0] rng_state = 32'd93144;
  logic        held;
  pixel_t      held_pix;
  int          stall_cnt;
  pixel_t      exp_q[$];
  pixel_t      got_q[$];
  pixel_t      ccw_q[$];

  raster_top raster_top_i (
    .clk_in(clk_in), .rst_in(rst_in),
    .tri_in(tri_in), .tri_valid(tri_valid), .tri_ready(tri_ready),
    .pix_out(pix_out), .pix_valid(pix_valid), .pix_ready(pix_ready)
  );

  initial begin
    clk_in = 1'b0;
    forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] r;
    r = s ^ (s << 13);
    r = r ^ (r >> 17);
    r = r ^ (r << 5);
    return r;
  endfunction

  task automatic abort_run();
    $display("sim failed");
    $fatal(1, "stopping at first failure");
  endtask

  // output monitor and pix_ready driver
  always @(posedge clk_in) begin
    if (rst_in) begin
      held      <= 1'b0;
      stall_cnt <= 0;
      pix_ready <= 1'b1;
    end else begin
      if (held && (!pix_valid || pix_out != held_pix)) begin
        $display("output pixel changed or dropped while pix_ready was low");
        abort_run();
      end
      if (pix_valid && pix_ready) got_q.push_back(pix_out);
      if (pix_valid && !pix_ready) stall_cnt <= stall_cnt + 1;
      held     <= pix_valid && !pix_ready;
      held_pix <= pix_out;
      if (bp_on) begin
        rng_state <= xorshift32(rng_state);
        pix_ready <= rng_state[3];
      end else begin
        pix_ready <= 1'b1;
      end
    end
  end

  initial begin
    #(longint'(WATCHDOG_CYCLES) * CLK_PERIOD);
    $display("watchdog: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    abort_run();
  end

  function automatic longint edge_val(input int ax, input int ay, input int bx,
                                      input int by, input int cx, input int cy);
    return longint'((bx - ax) * (cy - ay) - (by - ay) * (cx - ax));
  endfunction

  // expected pixels in raster order from the coverage and depth rules
  task automatic build_expected(input tri_t t);
    int     x[3];
    int     y[3];
    longint z[3];
    longint w[3];
    int     area;
    longint inv;
    longint sum;
    longint zval;
    int     lo_h, hi_h, lo_v, hi_v;
    pixel_t p;
    exp_q.delete();
    x[0] = $signed(t.v0.x);
    x[1] = $signed(t.v1.x);
    x[2] = $signed(t.v2.x);
    y[0] = $signed(t.v0.y);
    y[1] = $signed(t.v1.y);
    y[2] = $signed(t.v2.y);
    z[0] = t.v0.z;
    z[1] = t.v1.z;
    z[2] = t.v2.z;
    area = (x[1] - x[0]) * (y[2] - y[0]) - (x[2] - x[0]) * (y[1] - y[0]);
    if (area != 0) begin
      inv  = (longint'(1) << `RASTER_INV_FRAC) / ((area < 0) ? -area : area);
      lo_h = (x[0] < x[1]) ? x[0] : x[1];
      lo_h = (lo_h < x[2]) ? lo_h : x[2];
      hi_h = (x[0] > x[1]) ? x[0] : x[1];
      hi_h = (hi_h > x[2]) ? hi_h : x[2];
      lo_v = (y[0] < y[1]) ? y[0] : y[1];
      lo_v = (lo_v < y[2]) ? lo_v : y[2];
      hi_v = (y[0] > y[1]) ? y[0] : y[1];
      hi_v = (hi_v > y[2]) ? hi_v : y[2];
      if (lo_h < 0) lo_h = 0;  // frame clip
      if (lo_v < 0) lo_v = 0;
      if (hi_h > `RASTER_HRES - 1) hi_h = `RASTER_HRES - 1;
      if (hi_v > `RASTER_VRES - 1) hi_v = `RASTER_VRES - 1;
      for (int v = lo_v; v <= hi_v; v++) begin
        for (int h = lo_h; h <= hi_h; h++) begin
          w[0] = edge_val(x[1], y[1], x[2], y[2], h, v);
          w[1] = edge_val(x[2], y[2], x[0], y[0], h, v);
          w[2] = edge_val(x[0], y[0], x[1], y[1], h, v);
          if (area < 0) begin
            w[0] = -w[0];
            w[1] = -w[1];
            w[2] = -w[2];
          end
          if (w[0] >= 0 && w[1] >= 0 && w[2] >= 0) begin
            sum  = w[0] * z[0] + w[1] * z[1] + w[2] * z[2];
            zval = (sum * inv) >>> `RASTER_INV_FRAC;
            p.h  = h[`RASTER_HW-1:0];
            p.v  = v[`RASTER_VW-1:0];
            p.z  = zval[`RASTER_ZW-1:0];
            exp_q.push_back(p);
          end
        end
      end
    end
  endtask

  function automatic vertex_t make_vertex(input int x, input int y, input int z);
    vertex_t vx;
    vx.x = x[`RASTER_HW-1:0];
    vx.y = y[`RASTER_VW-1:0];
    vx.z = z[`RASTER_ZW-1:0];
    return vx;
  endfunction

  // hand one triangle over and collect pixels until tri_ready comes back
  task automatic run_triangle(input tri_t t);
    got_q.delete();
    @(posedge clk_in);
    tri_in    <= t;
    tri_valid <= 1'b1;
    do @(posedge clk_in); while (!tri_ready);
    tri_valid <= 1'b0;
    do @(posedge clk_in); while (!tri_ready);
  endtask

  task automatic check_pixel(input string name, input pixel_t exp, input pixel_t act);
    if (exp != act) begin
      $display("Error %s: expected h=%0d v=%0d z=%0d, actual h=%0d v=%0d z=%0d",
               name, exp.h, exp.v, exp.z, act.h, act.v, act.z);
      abort_run();
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp != act) begin
      $display("Error %s: expected count %0d, actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  task automatic compare_lists(input string name);
    check_count(name, exp_q.size(), got_q.size());
    foreach (exp_q[i]) check_pixel(name, exp_q[i], got_q[i]);
  endtask

  // area 128 makes the reciprocal exact, so z stays at z0
  task automatic test_flat_ccw();
    pixel_t flat;
    tri_t   t;
    t.v0 = make_vertex(2, 2, 7000);
    t.v1 = make_vertex(18, 2, 7000);
    t.v2 = make_vertex(2, 10, 7000);
    build_expected(t);
    run_triangle(t);
    check_count("flat_ccw", 81, got_q.size());  // rows of 17, 15, ... 1
    compare_lists("flat_ccw");
    flat = '{h: '0, v: '0, z: 16'd7000};
    foreach (got_q[i]) begin
      flat.h = got_q[i].h;
      flat.v = got_q[i].v;
      check_pixel("flat_ccw_z", flat, got_q[i]);
    end
    ccw_q = got_q;
  endtask

  task automatic test_flat_cw();
    tri_t t;
    t.v0 = make_vertex(2, 2, 7000);
    t.v1 = make_vertex(2, 10, 7000);
    t.v2 = make_vertex(18, 2, 7000);
    build_expected(t);
    run_triangle(t);
    compare_lists("flat_cw");
    check_count("flat_cw_vs_ccw", ccw_q.size(), got_q.size());
    foreach (ccw_q[i]) check_pixel("flat_cw_vs_ccw", ccw_q[i], got_q[i]);
  endtask

  task automatic test_gradient();
    tri_t t;
    t.v0 = make_vertex(4, 5, 100);
    t.v1 = make_vertex(20, 9, 5000);
    t.v2 = make_vertex(10, 22, 60000);
    build_expected(t);
    run_triangle(t);
    compare_lists("gradient");
  endtask

  task automatic test_zero_area();
    tri_t t;
    t.v0 = make_vertex(3, 3, 500);
    t.v1 = make_vertex(10, 10, 600);
    t.v2 = make_vertex(20, 20, 700);
    run_triangle(t);
    check_count("zero_area", 0, got_q.size());
  endtask

  task automatic test_backpressure();
    tri_t t;
    t.v0 = make_vertex(1, 3, 1000);
    t.v1 = make_vertex(30, 8, 40000);
    t.v2 = make_vertex(9, 29, 20000);
    build_expected(t);
    bp_on <= 1'b1;
    run_triangle(t);
    bp_on <= 1'b0;
    compare_lists("backpressure");
    if (stall_cnt == 0) begin
      $display("back-pressure test never stalled the output");
      abort_run();
    end
  endtask

  // corners above and left of the frame
  task automatic test_clipped();
    tri_t t;
    t.v0 = make_vertex(-10, -6, 300);
    t.v1 = make_vertex(25, -2, 900);
    t.v2 = make_vertex(3, 20, 2000);
    build_expected(t);
    run_triangle(t);
    compare_lists("clipped");
  endtask

  initial begin
    rst_in    = 1'b1;
    tri_valid = 1'b0;
    tri_in    = '0;
    bp_on     = 1'b0;
    repeat (8) @(posedge clk_in);
    rst_in <= 1'b0;
    @(posedge clk_in);
    if (!tri_ready || pix_valid) begin
      $display("after reset tri_ready is not high or pix_valid is not low");
      abort_run();
    end
    test_flat_ccw();
    test_flat_cw();
    test_gradient();
    test_zero_area();
    test_backpressure();
    test_clipped();
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire
